// File: compile.f
+incdir+include
logic/rv32i_isa_pkg.sv
logic/alu_pkg.sv
logic/alu_shifter.sv
logic/alu_decoder.sv
logic/alu_exec.sv
logic/friscv_alu.sv
sim/tb_friscv_alu.sv

// File: Bender.yml
package:
  name: friscv_alu

export_include_dirs:
  - include

sources:
  - logic/rv32i_isa_pkg.sv
  - logic/alu_pkg.sv
  - logic/alu_shifter.sv
  - logic/alu_decoder.sv
  - logic/alu_exec.sv
  - logic/friscv_alu.sv
  - target: simulation
    files:
      - sim/tb_friscv_alu.sv

// File: sim/tb_friscv_alu.sv
/*
 * RV32I ALU testbench
 */

`timescale 1ns/1ps

`include "alu_defines.svh"

module tb_friscv_alu
    import rv32i_isa_pkg::*;
    import alu_pkg::*;
();

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam int         MAX_CYCLES = 2000;

    logic                   aclk;
    logic                   arst_n;
    logic                   alu_en;
    inst_u                  alu_instbus;
    logic [`REG_ADDR_W-1:0] alu_rs1_addr;
    logic [`REG_ADDR_W-1:0] alu_rs2_addr;
    alu_wb_t                alu_wb;

    logic [`XLEN-1:0] regs [32];
    logic [15:0]      lfsr;
    alu_wb_t          exp_q [$];
    string            test_name;
    int               checks;
    int               errors;
    int               test_checks;
    int               test_errors;

    // register file model answers in the same cycle
    friscv_alu DUT (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .alu_en       (alu_en),
        .alu_instbus  (alu_instbus),
        .alu_rs1_addr (alu_rs1_addr),
        .alu_rs1_val  (regs[alu_rs1_addr]),
        .alu_rs2_addr (alu_rs2_addr),
        .alu_rs2_val  (regs[alu_rs2_addr]),
        .alu_wb       (alu_wb)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge aclk);
        end
        $display("simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_word(input logic [2:0] f3, input logic alt);
        return {1'b0, alt, 5'b0, 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
                5'(rand_bits(5)), OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'(rand_bits(5)), f3, 5'(rand_bits(5)), OPC_OP_IMM};
    endfunction

    // add, slt, sltu, xor, or, and only
    function automatic logic [2:0] arith_f3();
        logic [2:0] f3;
        f3 = 3'(rand_bits(3));
        return (f3 == 3'b001 || f3 == 3'b101) ? 3'b000 : f3;
    endfunction

    // load, store, branch, lui
    function automatic logic [31:0] other_word();
        logic [6:0] opc [4];
        logic [31:0] w;
        opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b0110111};
        w = r_word(3'(rand_bits(3)), 1'(rand_bits(1)));
        return {w[31:7], opc[2'(rand_bits(2))]};
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic alu_wb_t model_write(input logic [31:0] word, input logic en);
        alu_wb_t     w;
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc    = word[6:0];
        a      = regs[word[19:15]];
        b      = (opc == OPC_OP_IMM) ? {{20{word[31]}}, word[31:20]} : regs[word[24:20]];
        sh     = b[4:0];
        w.wr   = en && (opc == OPC_OP || opc == OPC_OP_IMM);
        w.addr = word[11:7];
        case (word[14:12])
            3'b000:  w.val = (opc == OPC_OP && word[30]) ? a - b : a + b;
            3'b001:  w.val = a << sh;
            3'b010:  w.val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  w.val = (a < b) ? 32'd1 : 32'd0;
            3'b100:  w.val = a ^ b;
            3'b101: begin
                if (word[30]) begin
                    w.val = $signed(a) >>> sh;
                end else begin
                    w.val = a >> sh;
                end
            end
            3'b110:  w.val = a | b;
            default: w.val = a & b;
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic compare_val(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        test_checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pending();
        alu_wb_t     e;
        logic [31:0] w;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            w = alu_instbus;
            compare_val({test_name, " wr"}, 32'(e.wr), 32'(alu_wb.wr));
            if (e.wr) begin
                compare_val({test_name, " addr"}, 32'(e.addr), 32'(alu_wb.addr));
                compare_val({test_name, " val"}, e.val, alu_wb.val);
            end
            // source indexes of the word still on the bus
            compare_val({test_name, " rs1 addr"}, 32'(w[19:15]), 32'(alu_rs1_addr));
            compare_val({test_name, " rs2 addr"}, 32'(w[24:20]), 32'(alu_rs2_addr));
        end
    endtask

    task automatic wait_idle();
        int c;
        c = 0;
        while (alu_wb.wr !== 1'b0 && c < 10) begin
            @(negedge aclk);
            c++;
        end
        if (alu_wb.wr !== 1'b0) begin
            errors++;
            test_errors++;
            $display("%s: write strobe did not drop within 10 cycles", test_name);
        end
    endtask

    // result is due one cycle later, checked before the next drive
    task automatic issue(input logic [31:0] word, input logic en);
        @(negedge aclk);
        check_pending();
        alu_en      = en;
        alu_instbus = word;
        exp_q.push_back(model_write(word, en));
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        @(negedge aclk);
        check_pending();
        alu_en = 1'b0;
        wait_idle();
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [2:0] f3;
        logic       alt;
        lfsr        = 16'd47505;
        checks      = 0;
        errors      = 0;
        arst_n      = 1'b0;
        alu_en      = 1'b0;
        alu_instbus = r_word(3'b000, 1'b0);
        regs[0]     = '0;
        for (int r = 1; r < 32; r++) begin
            regs[r] = rand_bits(32);
        end

        begin_test("reset");
        for (int c = 0; c < 3; c++) begin
            @(negedge aclk);
            compare_val("reset wr", 32'd0, 32'(alu_wb.wr));
            compare_val("reset val", 32'd0, alu_wb.val);
        end
        arst_n = 1'b1;
        wait_idle();
        for (int c = 0; c < 5; c++) begin
            @(negedge aclk);
            alu_instbus = r_word(arith_f3(), 1'b0);
            compare_val("idle wr", 32'd0, 32'(alu_wb.wr));
            compare_val("idle val", 32'd0, alu_wb.val);
        end
        end_test();

        begin_test("r_type");
        for (int n = 0; n < 80; n++) begin
            f3 = arith_f3();
            issue(r_word(f3, f3 == 3'b000 && rand_bits(1)), 1'b1);
        end
        end_test();

        begin_test("i_type");
        issue(i_word(3'b011, 12'hfff), 1'b1);
        issue(i_word(3'b011, 12'h800), 1'b1);
        issue(i_word(3'b010, 12'h7ff), 1'b1);
        for (int n = 0; n < 80; n++) begin
            issue(i_word(arith_f3(), 12'(rand_bits(12))), 1'b1);
        end
        end_test();

        begin_test("shifts");
        for (int n = 0; n < 80; n++) begin
            f3  = rand_bits(1) ? 3'b101 : 3'b001;
            alt = (f3 == 3'b101) && rand_bits(1);
            if (rand_bits(1)) begin
                issue(r_word(f3, alt), 1'b1);
            end else begin
                issue(i_word(f3, {1'b0, alt, 4'b0, 6'(rand_bits(6))}), 1'b1);
            end
        end
        end_test();

        begin_test("no_write");
        for (int n = 0; n < 40; n++) begin
            if (rand_bits(1)) begin
                issue(r_word(arith_f3(), 1'b0), 1'b0);
            end else begin
                issue(other_word(), 1'b1);
            end
        end
        end_test();

        begin_test("stream");
        for (int n = 0; n < 300; n++) begin
            f3 = 3'(rand_bits(3));
            if (rand_bits(1)) begin
                issue(r_word(f3, 1'(rand_bits(1))), 1'b1);
            end else begin
                issue(i_word(f3, 12'(rand_bits(12))), 1'b1);
            end
        end
        end_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: logic/friscv_alu.sv
/*
 * RV32I integer ALU
 */

`timescale 1ns/1ps

`include "alu_defines.svh"

module friscv_alu
    import rv32i_isa_pkg::*;
    import alu_pkg::*;
(
    input  logic                   aclk,
    input  logic                   arst_n,
    // instruction in
    input  logic                   alu_en,
    input  inst_u                  alu_instbus,
    // register file reads, answered in the same cycle
    output logic [`REG_ADDR_W-1:0] alu_rs1_addr,
    input  logic [`XLEN-1:0]       alu_rs1_val,
    output logic [`REG_ADDR_W-1:0] alu_rs2_addr,
    input  logic [`XLEN-1:0]       alu_rs2_val,
    // registered destination write
    output alu_wb_t                alu_wb
);

    alu_ctrl_t ctrl;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    alu_decoder u_decoder (
        .inst     (alu_instbus),
        .ctrl     (ctrl),
        .rs1_addr (alu_rs1_addr),
        .rs2_addr (alu_rs2_addr)
    );

    ////////////////////////////////////////////////////////////
    // execute and writeback
    ////////////////////////////////////////////////////////////

    alu_exec u_exec (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .alu_en  (alu_en),
        .ctrl    (ctrl),
        .rs1_val (alu_rs1_val),
        .rs2_val (alu_rs2_val),
        .wb      (alu_wb)
    );

endmodule

// File: logic/alu_exec.sv
/*
 * ALU execute stage and writeback register
 */

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_exec
    import alu_pkg::*;
(
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             alu_en,
    input  alu_ctrl_t        ctrl,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    output alu_wb_t          wb
);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] add_res;
    logic [`XLEN-1:0] sub_res;
    logic             lt_s;
    logic             lt_u;
    logic [`XLEN-1:0] shift_res;
    logic [`XLEN-1:0] result;
    logic             wr_next;

    ////////////////////////////////////////////////////////////
    // operands and arithmetic
    ////////////////////////////////////////////////////////////

    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_val;

    assign add_res = rs1_val + op_b;
    assign sub_res = rs1_val - op_b;

    // sltiu compares against the sign-extended immediate as unsigned
    assign lt_s = ($signed(rs1_val) < $signed(op_b));
    assign lt_u = (rs1_val < op_b);

    alu_shifter u_shifter (
        .data   (rs1_val),
        .shamt  (op_b[`SHAMT_W-1:0]),
        .op     (ctrl.op),
        .result (shift_res)
    );

    always_comb begin
        case (ctrl.op)
            ALU_ADD:  result = add_res;
            ALU_SUB:  result = sub_res;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result = rs1_val ^ op_b;
            ALU_OR:   result = rs1_val | op_b;
            ALU_AND:  result = rs1_val & op_b;
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  result = shift_res;
            default:  result = add_res;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // writeback register
    ////////////////////////////////////////////////////////////

    assign wr_next = alu_en & ctrl.valid;

    // payload only moves on a real write
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.wr <= wr_next;
            if (wr_next) begin
                wb.addr <= ctrl.rd;
                wb.val  <= result;
            end
        end
    end

endmodule

// File: logic/alu_decoder.sv
/*
 * ALU instruction decoder
 */

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_decoder
    import rv32i_isa_pkg::*;
    import alu_pkg::*;
(
    input  inst_u                  inst,
    output alu_ctrl_t              ctrl,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr
);

    logic is_r;
    logic is_i;
    logic bit30;

    ////////////////////////////////////////////////////////////
    // format detection
    ////////////////////////////////////////////////////////////

    assign is_r  = (inst.r.opcode == OP_R_ARITH);
    assign is_i  = (inst.r.opcode == OP_I_ARITH);
    assign bit30 = inst.r.funct7[5];

    // register indexes follow the word even when it is not taken
    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    assign ctrl.valid   = is_r | is_i;
    assign ctrl.use_imm = is_i;
    assign ctrl.rd      = inst.r.rd;
    assign ctrl.imm     = {{(`XLEN-`IMM12_W){inst.i.imm12[`IMM12_W-1]}}, inst.i.imm12};

    ////////////////////////////////////////////////////////////
    // operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.op = ALU_ADD;
        case (inst.r.funct3)
            F3_ADD: begin
                // immediate form has no subtract
                if (is_r && bit30) begin
                    ctrl.op = ALU_SUB;
                end
            end
            F3_SLL: begin
                ctrl.op = ALU_SLL;
            end
            F3_SLT: begin
                ctrl.op = ALU_SLT;
            end
            F3_SLTU: begin
                ctrl.op = ALU_SLTU;
            end
            F3_XOR: begin
                ctrl.op = ALU_XOR;
            end
            F3_SR: begin
                ctrl.op = bit30 ? ALU_SRA : ALU_SRL;
            end
            F3_OR: begin
                ctrl.op = ALU_OR;
            end
            F3_AND: begin
                ctrl.op = ALU_AND;
            end
            default: begin
                ctrl.op = ALU_ADD;
            end
        endcase
    end

endmodule

// File: logic/alu_shifter.sv
/*
 * ALU barrel shifter
 */

`timescale 1ns/1ps

`include "alu_defines.svh"

module alu_shifter
    import alu_pkg::*;
(
    input  logic [`XLEN-1:0]    data,
    input  logic [`SHAMT_W-1:0] shamt,
    input  alu_op_e             op,
    output logic [`XLEN-1:0]    result
);

    logic [`XLEN-1:0] data_rev;
    logic [`XLEN-1:0] stage;
    logic [`XLEN-1:0] stage_rev;
    logic             left;
    logic             fill;

    // left shift runs through the right shifter on reversed bits
    assign left = (op == ALU_SLL);
    assign fill = (op == ALU_SRA) & data[`XLEN-1];

    always_comb begin
        for (int b = 0; b < `XLEN; b++) begin
            data_rev[b] = data[`XLEN-1-b];
        end
    end

    ////////////////////////////////////////////////////////////
    // log2 stages, one per shamt bit
    ////////////////////////////////////////////////////////////

    always_comb begin
        stage = left ? data_rev : data;
        for (int s = 0; s < `SHAMT_W; s++) begin
            if (shamt[s]) begin
                stage = (stage >> (1 << s)) | ({`XLEN{fill}} << (`XLEN - (1 << s)));
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `XLEN; b++) begin
            stage_rev[b] = stage[`XLEN-1-b];
        end
    end

    assign result = left ? stage_rev : stage;

endmodule

// File: logic/alu_pkg.sv
/*
 * ALU control and writeback types
 */

`include "alu_defines.svh"

package alu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // decoder to execute stage
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
    } alu_ctrl_t;

    // destination register write
    typedef struct packed {
        logic                   wr;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       val;
    } alu_wb_t;

endpackage

// File: logic/rv32i_isa_pkg.sv
/*
 * RV32I instruction formats
 */

`include "alu_defines.svh"

package rv32i_isa_pkg;

    ////////////////////////////////////////////////////////////
    // opcode and funct3 codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_I_ARITH = 7'b0010011,
        OP_R_ARITH = 7'b0110011
    } opcode_e;

    // shared by register and immediate forms
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    ////////////////////////////////////////////////////////////
    // instruction layouts
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } r_inst_t;

    typedef struct packed {
        logic [`IMM12_W-1:0]    imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } i_inst_t;

    // one word, two views, the opcode picks the one that applies
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

endpackage

// File: include/alu_defines.svh
/*
 * RV32I ALU widths
 */

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////

`define XLEN        32

// register file index
`define REG_ADDR_W  5

// low bits of operand b used by shifts
`define SHAMT_W     5

////////////////////////////////////////////////////////////
// instruction word
////////////////////////////////////////////////////////////

`define INST_W      32
`define IMM12_W     12

`endif
